//--- spi_bridge_defines.svh
`ifndef SPI_BRIDGE_DEFINES_SVH
`define SPI_BRIDGE_DEFINES_SVH

// ************************************************
// device and register bank constants
// ************************************************

`define SPI_DEVICE_ID 8'hA5  // first byte returned in every frame.

`define REG_COUNT     16     // number of byte registers in the bank.

`define REG_ADDR_W    4      // width of a register address.

`endif

//--- spi_bridge_pkg.sv
`include "spi_bridge_defines.svh"

package spi_bridge_pkg;

    // ************************************************
    // wishbone classic request and response
    // ************************************************
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`REG_ADDR_W-1:0] adr;
        logic [7:0]             dat;  // write data.
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;  // read data, valid while ack is high.
    } wb_rsp_t;

    typedef struct packed {
        logic       valid;  // one-cycle strobe.
        logic [7:0] data;
    } spi_byte_t;

    typedef enum logic {OP_READ = 1'b0, OP_WRITE = 1'b1} cmd_op_t;

    typedef enum logic [1:0] {DEC_CMD, DEC_DATA, DEC_BUS} dec_state_t;

endpackage

//--- spi_byte_trx.sv
`timescale 1ns/1ps

module spi_byte_trx (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      sck_i,
    input  logic                      ss_i,
    input  logic                      mosi_i,
    input  spi_bridge_pkg::spi_byte_t tx_i,
    output logic                      miso_o,
    output logic                      frame_start_o,
    output spi_bridge_pkg::spi_byte_t rx_o
);

    logic [1:0] sck_hist;
    logic [1:0] ss_hist;
    logic [1:0] mosi_hist;
    logic       ss_negedge;
    logic       ss_active;
    logic       sck_posedge;
    logic       sck_negedge;
    logic [2:0] rise_cnt;
    logic [2:0] fall_cnt;
    logic       rise8;
    logic       fall8;
    logic       rise8_dly;
    logic [7:0] shift_in;
    logic       rx_valid_q;
    logic [7:0] rx_data_q;
    logic [7:0] tx_latch;
    logic [7:0] shift_out;
    logic       first_pending;

    // ************************************************
    // input history and edge detection
    // ************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sck_hist <= 2'b00;
            ss_hist  <= 2'b11;  // idle high so reset never looks like a frame start.
        end else begin
            sck_hist <= {sck_hist[0], sck_i};
            ss_hist  <= {ss_hist[0], ss_i};
        end
        mosi_hist <= {mosi_hist[0], mosi_i};
    end

    assign ss_negedge  = (ss_hist == 2'b10);
    assign ss_active   = ~ss_hist[0];
    assign sck_posedge = ss_active && (sck_hist == 2'b01);
    assign sck_negedge = ss_active && (sck_hist == 2'b10);

    // separate edge counters, both restarted by each frame.
    always_ff @(posedge clk) begin
        if (rst_i || ss_negedge) begin
            rise_cnt <= '0;
            fall_cnt <= '0;
        end else begin
            if (sck_posedge) rise_cnt <= rise_cnt + 1'b1;
            if (sck_negedge) fall_cnt <= fall_cnt + 1'b1;
        end
    end

    assign rise8 = sck_posedge && (rise_cnt == 3'd7);
    assign fall8 = sck_negedge && (fall_cnt == 3'd7);

    // ************************************************
    // receive path
    // ************************************************
    always_ff @(posedge clk) begin
        if (sck_posedge) shift_in <= {shift_in[6:0], mosi_hist[1]};  // msb first.
        if (rise8_dly) rx_data_q <= shift_in;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rise8_dly     <= 1'b0;
            rx_valid_q    <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            rise8_dly     <= rise8;       // lets the eighth bit land in shift_in.
            rx_valid_q    <= rise8_dly;
            frame_start_o <= ss_negedge;
        end
    end

    assign rx_o = '{valid: rx_valid_q, data: rx_data_q};

    // ************************************************
    // transmit path
    // ************************************************
    always_ff @(posedge clk) begin
        if (tx_i.valid) tx_latch <= tx_i.data;
    end

    // the identifier is offered after the SS edge, so it goes straight to the shifter.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            first_pending <= 1'b0;
            shift_out     <= '0;
        end else begin
            if (ss_negedge) first_pending <= 1'b1;
            else if (sck_negedge) first_pending <= 1'b0;
            if (ss_negedge || fall8) shift_out <= tx_latch;
            else if (tx_i.valid && first_pending) shift_out <= tx_i.data;
            else if (sck_negedge) shift_out <= {shift_out[6:0], 1'b0};
        end
    end

    assign miso_o = shift_out[7];

endmodule

//--- spi_cmd_decoder.sv
`timescale 1ns/1ps
`include "spi_bridge_defines.svh"

module spi_cmd_decoder (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      frame_start_i,
    input  spi_bridge_pkg::spi_byte_t rx_i,
    input  spi_bridge_pkg::wb_rsp_t   wb_rsp_i,
    output spi_bridge_pkg::spi_byte_t tx_o,
    output spi_bridge_pkg::wb_req_t   wb_req_o
);

    import spi_bridge_pkg::*;

    dec_state_t             state;
    cmd_op_t                op;
    cmd_op_t                rx_op;
    logic [`REG_ADDR_W-1:0] addr;     // address of the byte being moved now.
    logic [`REG_ADDR_W-1:0] next_addr;
    logic                   bus_cyc;  // drives both cyc and stb.
    logic                   bus_we;
    logic [`REG_ADDR_W-1:0] bus_adr;
    logic [7:0]             bus_dat;
    logic                   tx_valid;
    logic [7:0]             tx_data;

    assign rx_op     = cmd_op_t'(rx_i.data[7]);
    assign next_addr = addr + 1'b1;  // wraps from 15 to 0.

    // ************************************************
    // frame protocol FSM
    // ************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= DEC_CMD;
            op       <= OP_READ;
            bus_cyc  <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= 1'b0;
            if (frame_start_i) begin
                state    <= DEC_CMD;
                bus_cyc  <= 1'b0;
                tx_valid <= 1'b1;
                tx_data  <= `SPI_DEVICE_ID;  // goes out while the command comes in.
            end else begin
                case (state)
                    DEC_CMD: begin
                        if (rx_i.valid) begin
                            op      <= rx_op;
                            addr    <= rx_i.data[`REG_ADDR_W-1:0];
                            bus_adr <= rx_i.data[`REG_ADDR_W-1:0];
                            bus_we  <= 1'b0;
                            if (rx_op == OP_READ) begin
                                bus_cyc <= 1'b1;  // prefetch the first register.
                                state   <= DEC_BUS;
                            end else begin
                                state <= DEC_DATA;
                            end
                        end
                    end
                    DEC_DATA: begin
                        if (rx_i.valid) begin
                            addr    <= next_addr;
                            bus_cyc <= 1'b1;
                            state   <= DEC_BUS;
                            if (op == OP_WRITE) begin
                                bus_we  <= 1'b1;
                                bus_adr <= addr;
                                bus_dat <= rx_i.data;
                            end else begin
                                bus_we  <= 1'b0;
                                bus_adr <= next_addr;  // prefetch for the next byte.
                            end
                        end
                    end
                    DEC_BUS: begin
                        if (wb_rsp_i.ack) begin
                            bus_cyc <= 1'b0;
                            state   <= DEC_DATA;
                            if (!bus_we) begin
                                tx_valid <= 1'b1;
                                tx_data  <= wb_rsp_i.dat;
                            end
                        end
                    end
                    default: begin
                        state <= DEC_CMD;
                    end
                endcase
            end
        end
    end

    // classic cycle, so stb simply follows cyc.
    assign wb_req_o = '{cyc: bus_cyc, stb: bus_cyc, we: bus_we, adr: bus_adr, dat: bus_dat};
    assign tx_o     = '{valid: tx_valid, data: tx_data};

endmodule

//--- wb_reg_bank.sv
`timescale 1ns/1ps
`include "spi_bridge_defines.svh"

module wb_reg_bank (
    input  logic                    clk,
    input  logic                    rst_i,
    input  spi_bridge_pkg::wb_req_t wb_req_i,
    output spi_bridge_pkg::wb_rsp_t wb_rsp_o,
    output logic [7:0]              ctrl_reg_o
);

    logic [7:0] regs [`REG_COUNT];
    logic       ack_q;
    logic [7:0] rd_dat_q;
    logic       access;

    // a new access is one not yet acknowledged.
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    // ************************************************
    // handshake and register file
    // ************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;  // high for exactly one cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (access && wb_req_i.we) begin
            regs[wb_req_i.adr] <= wb_req_i.dat;  // lands on the ack edge.
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat_q <= regs[wb_req_i.adr];
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rd_dat_q};

    // register 0 is the control byte seen outside.
    assign ctrl_reg_o = regs[0];

endmodule

//--- spi_wb_bridge_top.sv
`timescale 1ns/1ps

module spi_wb_bridge_top (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       sck_i,
    input  logic       ss_i,
    input  logic       mosi_i,
    output logic       miso_o,
    output logic [7:0] ctrl_reg_o
);

    import spi_bridge_pkg::*;

    spi_byte_t rx_byte;      // received bytes towards the decoder.
    spi_byte_t tx_byte;      // next byte offered for MISO.
    logic      frame_start;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;

    spi_byte_trx i_trx (
        .clk          (clk),
        .rst_i        (rst_i),
        .sck_i        (sck_i),
        .ss_i         (ss_i),
        .mosi_i       (mosi_i),
        .tx_i         (tx_byte),
        .miso_o       (miso_o),
        .frame_start_o(frame_start),
        .rx_o         (rx_byte)
    );

    spi_cmd_decoder i_decoder (
        .clk          (clk),
        .rst_i        (rst_i),
        .frame_start_i(frame_start),
        .rx_i         (rx_byte),
        .wb_rsp_i     (wb_rsp),
        .tx_o         (tx_byte),
        .wb_req_o     (wb_req)
    );

    wb_reg_bank i_bank (
        .clk       (clk),
        .rst_i     (rst_i),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .ctrl_reg_o(ctrl_reg_o)
    );

endmodule

//--- tb_spi_bridge.sv
`timescale 1ns/1ps
`include "spi_bridge_defines.svh"

module tb_spi_bridge;

    import spi_bridge_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    localparam int HALF           = 10;  // clk cycles per SCK half period.
    localparam int NUM_FRAMES     = 69;
    localparam int MAX_BYTES      = 6;
    localparam int FRAME_CYCLES   = MAX_BYTES * 16 * HALF + 4 * HALF + 4;
    localparam int TIMEOUT_CYCLES = (NUM_FRAMES * FRAME_CYCLES * 3) / 2 + 20;

    logic       clk;
    logic       rst_i;
    logic       sck_i;
    logic       ss_i;
    logic       mosi_i;
    logic       miso_o;
    logic [7:0] ctrl_reg_o;

    logic [7:0] ref_regs [`REG_COUNT];  // expected register contents.
    logic [31:0] lfsr_state;
    spi_byte_t  exp_q [$];               // valid marks bytes that are compared.
    logic [7:0] act_q [$];
    byte_q_t    none;

    spi_wb_bridge_top i_dut (
        .clk       (clk),
        .rst_i     (rst_i),
        .sck_i     (sck_i),
        .ss_i      (ss_i),
        .mosi_i    (mosi_i),
        .miso_o    (miso_o),
        .ctrl_reg_o(ctrl_reg_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // **************************************************
    // random numbers and reference model
    // **************************************************
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic byte_q_t ref_frame(input logic [7:0] cmd, input byte_q_t data);
        byte_q_t    exp_bytes;
        logic [3:0] adr;
        exp_bytes = {};
        exp_bytes.push_back(`SPI_DEVICE_ID);
        adr = cmd[3:0];
        foreach (data[i]) begin
            if (cmd[7]) begin
                ref_regs[adr] = data[i];
                exp_bytes.push_back(8'h00);  // not compared on writes.
            end else begin
                exp_bytes.push_back(ref_regs[adr]);
            end
            adr = adr + 1'b1;  // wraps from 15 to 0.
        end
        return exp_bytes;
    endfunction

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic check_miso(input spi_byte_t exp_byte, input logic [7:0] act);
        if (act !== exp_byte.data) begin
            $display("error miso_o: expected %h, got %h", exp_byte.data, act);
            $display("RESULT: FAIL");
            $fatal(1, "miso byte mismatch");
        end
    endtask

    task automatic check_ctrl(input logic [7:0] exp_val, input logic [7:0] act);
        if (act !== exp_val) begin
            $display("error ctrl_reg_o: expected %h, got %h", exp_val, act);
            $display("RESULT: FAIL");
            $fatal(1, "ctrl register mismatch");
        end
    endtask

    // **************************************************
    // SPI master, mode 0
    // **************************************************
    task automatic spi_frame(input byte_q_t tx_bytes, output byte_q_t rx_bytes);
        logic [7:0] rx_val;
        rx_bytes = {};
        rx_val   = '0;
        @(posedge clk);
        ss_i   <= 1'b0;
        mosi_i <= tx_bytes[0][7];
        for (int b = 0; b < tx_bytes.size(); b++) begin
            for (int i = 7; i >= 0; i--) begin
                repeat (HALF) @(posedge clk);
                sck_i <= 1'b1;
                @(negedge clk);
                rx_val = {rx_val[6:0], miso_o};  // miso is steady around the rising edge.
                repeat (HALF) @(posedge clk);
                sck_i <= 1'b0;
                if (i > 0) mosi_i <= tx_bytes[b][i-1];
                else if (b + 1 < tx_bytes.size()) mosi_i <= tx_bytes[b+1][7];
            end
            rx_bytes.push_back(rx_val);
        end
        repeat (HALF) @(posedge clk);
        ss_i <= 1'b1;
        repeat (2 * HALF) @(posedge clk);
    endtask

    task automatic run_frame(input logic [7:0] cmd, input byte_q_t data);
        byte_q_t exp_bytes;
        byte_q_t tx_bytes;
        byte_q_t rx_bytes;
        exp_bytes = ref_frame(cmd, data);
        tx_bytes  = data;
        tx_bytes.push_front(cmd);
        spi_frame(tx_bytes, rx_bytes);
        foreach (rx_bytes[i]) begin
            exp_q.push_back(spi_byte_t'{valid: (i == 0) || !cmd[7], data: exp_bytes[i]});
            act_q.push_back(rx_bytes[i]);
        end
        @(negedge clk);
        check_ctrl(ref_regs[0], ctrl_reg_o);  // SS is high again here.
    endtask

    function automatic byte_q_t random_bytes(input int n);
        byte_q_t q;
        q = {};
        for (int i = 0; i < n; i++) q.push_back(take_bits(8));
        return q;
    endfunction

    // pops captured bytes and checks them against the model.
    initial begin : compare_miso
        spi_byte_t  exp_byte;
        logic [7:0] act;
        forever begin
            @(negedge clk);
            while (exp_q.size() > 0 && act_q.size() > 0) begin
                exp_byte = exp_q.pop_front();
                act      = act_q.pop_front();
                if (exp_byte.valid) check_miso(exp_byte, act);
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the SPI frames did not finish in the expected time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // **************************************************
    // test sequence
    // **************************************************
    initial begin : stimulus
        logic [3:0] adr;
        logic [7:0] cmd;
        logic [7:0] rnd_op;
        logic [7:0] rnd_adr;
        int         len;
        rst_i      = 1'b1;
        sck_i      = 1'b0;
        ss_i       = 1'b1;
        mosi_i     = 1'b0;
        lfsr_state = 32'hd87b;
        none       = {};
        for (int i = 0; i < `REG_COUNT; i++) ref_regs[i] = 8'h00;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        repeat (4) @(posedge clk);

        run_frame(8'h00, none);  // identifier only.
        for (int a = 0; a < `REG_COUNT; a++) begin
            run_frame({4'h0, a[3:0]}, random_bytes(1));
        end

        for (int i = 0; i < 10; i++) begin
            rnd_adr = take_bits(4);
            adr     = (i == 0) ? 4'd0 : rnd_adr[3:0];  // make sure register 0 is hit.
            run_frame({4'h8, adr}, random_bytes(1));
            run_frame({4'h0, adr}, random_bytes(1));
        end

        run_frame(8'h8E, random_bytes(4));  // wraps through 15, 0 and 1.
        run_frame(8'h0E, random_bytes(4));

        for (int i = 0; i < 30; i++) begin
            rnd_op  = take_bits(1);
            rnd_adr = take_bits(4);
            cmd     = {rnd_op[0], 3'b000, rnd_adr[3:0]};
            len     = 1 + (take_bits(8) % 5);
            run_frame(cmd, random_bytes(len));
        end

        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
spi_bridge_pkg.sv
spi_byte_trx.sv
spi_cmd_decoder.sv
wb_reg_bank.sv
spi_wb_bridge_top.sv
tb_spi_bridge.sv
